//--- filelist.f
hdl/mem_pkg.sv
hdl/word_store.sv
hdl/mem_selftest.sv
hdl/mem_bridge.sv
hdl/mem_subsystem.sv
verif/tb_clock.sv
verif/tb_mem_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ns --top-module tb_mem_subsystem \
    -f filelist.f -o tb_sim > sim.log 2>&1 \
    && ./obj_dir/tb_sim >> sim.log 2>&1 \
    || echo "simulation or build returned an error" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0

//--- verif/tb_mem_subsystem.sv
// directed tests with check task, LFSR stimulus and byte reference memory
`timescale 1ns/1ns

module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int ADDR_WIDTH = 12;
    localparam int TEST_WORDS = 16;
    localparam int WAIT_LIMIT = 2000;             // cycles before any wait gives up
    localparam int NUM_BYTES  = 2 ** ADDR_WIDTH;

    logic                  clk;
    logic                  resetn;
    logic                  read_a;
    logic                  read_b;
    logic                  write;
    logic                  refresh;
    logic [ADDR_WIDTH-1:0] addr;
    byte_t                 din;
    byte_t                 dout_a;
    byte_t                 dout_b;
    logic                  busy;
    logic [19:0]           total_written;
    logic                  fail_high;
    logic                  fail_low;

    byte_t       ref_mem [NUM_BYTES];   // expected byte per console address
    bit          known   [NUM_BYTES];   // address holds a defined byte
    logic [15:0] lfsr_state;
    int          write_count;           // writes the DUT should have counted

    tb_clock #(.PERIOD(20), .RESET_CYCLES(5)) u_clock (.clk(clk), .resetn(resetn));

    mem_subsystem #(.ADDR_WIDTH(ADDR_WIDTH), .TEST_WORDS(TEST_WORDS)) DUT (
        .clk(clk), .resetn(resetn),
        .read_a(read_a), .read_b(read_b), .write(write), .refresh(refresh),
        .addr(addr), .din(din), .dout_a(dout_a), .dout_b(dout_b),
        .busy(busy), .total_written(total_written),
        .fail_high(fail_high), .fail_low(fail_low)
    );

    // galois step with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[14:0], lfsr_state[0]};   // one step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // byte left by the self-test where an odd address picks the high lane
    function automatic byte_t residue_byte(input logic [ADDR_WIDTH-1:0] byte_addr);
        byte_t word_idx;
        word_idx = byte_addr[8:1];
        if (byte_addr[0])
            return word_idx ^ 8'h5A;
        return ~word_idx;
    endfunction

    task automatic report_fail();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s actual=%0h expected=%0h", $time, name, actual, expected);
            report_fail();
        end
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (busy) begin
            $display("timeout: busy never fell while waiting for %s", what);
            report_fail();
        end
    endtask

    // one-cycle strobe with busy low and a wait for the access to finish
    task automatic pulse_strobes(input logic rd_a, input logic rd_b, input logic wr,
                                 input logic rf, input logic [ADDR_WIDTH-1:0] a,
                                 input byte_t d, input string what);
        read_a  = rd_a;
        read_b  = rd_b;
        write   = wr;
        refresh = rf;
        addr    = a;
        din     = d;
        @(posedge clk);
        #2;
        read_a  = 1'b0;
        read_b  = 1'b0;
        write   = 1'b0;
        refresh = 1'b0;
        check("busy", 32'(busy), 32'd1);   // accepted strobe raises busy
        wait_idle(what);
    endtask

    task automatic write_byte(input logic [ADDR_WIDTH-1:0] a, input byte_t d);
        pulse_strobes(1'b0, 1'b0, 1'b1, 1'b0, a, d, "write");
        ref_mem[a] = d;
        known[a]   = 1'b1;
        write_count++;
        check("total_written", 32'(total_written), 32'(write_count));
    endtask

    task automatic read_byte(input logic use_a, input logic use_b,
                             input logic [ADDR_WIDTH-1:0] a);
        pulse_strobes(use_a, use_b, 1'b0, 1'b0, a, 8'h00, "read");
        if (use_a)
            check("dout_a", 32'(dout_a), 32'(ref_mem[a]));
        if (use_b)
            check("dout_b", 32'(dout_b), 32'(ref_mem[a]));
    endtask

    // read back every address with a defined byte through port a
    task automatic verify_known();
        for (int a = 0; a < NUM_BYTES; a++) begin
            if (known[a])
                read_byte(1'b1, 1'b0, ADDR_WIDTH'(a));
        end
    endtask

    task automatic startup_and_selftest();
        int n;
        n = 0;
        while (!resetn && n < WAIT_LIMIT) begin   // resetn sampled on the edge
            @(posedge clk);
            n++;
        end
        if (!resetn) begin
            $display("timeout: reset was never released");
            report_fail();
        end
        #2;
        check("busy", 32'(busy), 32'd1);          // init and self-test still running
        wait_idle("init and self-test");
        check("fail_high", 32'(fail_high), 32'd0);
        check("fail_low", 32'(fail_low), 32'd0);
        check("total_written", 32'(total_written), 32'd0);
    endtask

    task automatic selftest_residue();
        for (int a = 0; a < 2 * TEST_WORDS; a++) begin
            ref_mem[a] = residue_byte(ADDR_WIDTH'(a));
            known[a]   = 1'b1;
            read_byte(1'b1, 1'b0, ADDR_WIDTH'(a));
        end
    endtask

    task automatic random_write_readback();
        logic [15:0]           bits;
        logic [ADDR_WIDTH-1:0] a;
        for (int i = 0; i < 32; i++) begin
            if (i < 16) begin
                take_bits(ADDR_WIDTH, bits);      // anywhere in the space
                a = bits[ADDR_WIDTH-1:0];
            end else begin
                take_bits(6, bits);               // crowd the self-test words
                a = {6'd0, bits[5:0]};
            end
            take_bits(8, bits);
            write_byte(a, bits[7:0]);
        end
        verify_known();                           // neighbour lanes read back too
        check("total_written", 32'(total_written), 32'(write_count));
    endtask

    task automatic dual_port_reads();
        byte_t keep;
        write_byte(12'h800, 8'hC3);
        write_byte(12'h801, 8'h3C);
        keep = dout_b;
        read_byte(1'b1, 1'b0, 12'h800);
        check("dout_b", 32'(dout_b), 32'(keep));  // port b left alone
        read_byte(1'b0, 1'b1, 12'h801);
        check("dout_a", 32'(dout_a), 32'hC3);     // port a left alone
        read_byte(1'b1, 1'b1, 12'h800);           // same byte on both ports
        read_byte(1'b1, 1'b1, 12'h801);
    endtask

    task automatic refresh_and_dropped_strobes();
        byte_t keep_a;
        keep_a  = dout_a;
        refresh = 1'b1;
        @(posedge clk);
        #2;
        refresh = 1'b0;
        check("busy", 32'(busy), 32'd1);
        write = 1'b1;                             // dropped while busy is high
        addr  = 12'h801;
        din   = ~ref_mem[12'h801];
        @(posedge clk);
        #2;
        check("busy", 32'(busy), 32'd1);
        write  = 1'b0;
        read_a = 1'b1;                            // dropped as well
        addr   = 12'h800;
        @(posedge clk);
        #2;
        read_a = 1'b0;
        wait_idle("refresh");
        check("dout_a", 32'(dout_a), 32'(keep_a));
        check("total_written", 32'(total_written), 32'(write_count));
        verify_known();
    endtask

    initial begin
        read_a      = 1'b0;
        read_b      = 1'b0;
        write       = 1'b0;
        refresh     = 1'b0;
        addr        = '0;
        din         = '0;
        lfsr_state  = 16'd36630;
        write_count = 0;
        foreach (known[i]) known[i] = 1'b0;
        startup_and_selftest();
        selftest_residue();
        random_write_readback();
        dual_port_reads();
        refresh_and_dropped_strobes();
        $display("Test OK");
        $finish;
    end

endmodule

//--- verif/tb_clock.sv
// testbench clock and active-low reset generator
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD       = 20,   // clock period in ns
    parameter int RESET_CYCLES = 5     // rising edges seen with resetn low
) (
    output logic clk,
    output logic resetn
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        resetn = 1'b1;   // released 2 ns after the edge
    end

endmodule

//--- hdl/mem_subsystem.sv
// top level joining bridge, self-test engine and word store
`timescale 1ns/1ns

module mem_subsystem #(
    parameter int ADDR_WIDTH     = 22,
    parameter int INIT_CYCLES    = 200,
    parameter int ACCESS_CYCLES  = 3,
    parameter int REFRESH_CYCLES = 6,
    parameter int TEST_WORDS     = 16
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  read_a,
    input  logic                  read_b,
    input  logic                  write,
    input  logic                  refresh,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  mem_pkg::byte_t        din,
    output mem_pkg::byte_t        dout_a,
    output mem_pkg::byte_t        dout_b,
    output logic                  busy,
    output logic [19:0]           total_written,
    output logic                  fail_high,
    output logic                  fail_low
);
    import mem_pkg::*;

    // bridge to store
    logic                  mem_rd;
    logic                  mem_wr;
    logic                  mem_refresh;
    logic [ADDR_WIDTH-2:0] mem_addr;
    word_t                 mem_din;
    logic [WORD_BYTES-1:0] mem_wmask;
    // store back to bridge and self-test
    word_t                 mem_dout;
    logic                  mem_data_ready;
    logic                  mem_busy;
    // self-test to bridge
    logic                  test_start;
    logic                  test_running;
    logic                  test_rd;
    logic                  test_wr;
    logic                  test_fail_high;
    logic                  test_fail_low;
    logic [ADDR_WIDTH-2:0] test_addr;
    word_t                 test_din;

    mem_bridge #(.ADDR_WIDTH(ADDR_WIDTH)) u_bridge (
        .clk(clk), .resetn(resetn),
        .read_a(read_a), .read_b(read_b), .write(write), .refresh(refresh),
        .addr(addr), .din(din), .dout_a(dout_a), .dout_b(dout_b),
        .busy(busy), .total_written(total_written),
        .test_running(test_running), .fail_high_in(test_fail_high), .fail_low_in(test_fail_low),
        .test_rd(test_rd), .test_wr(test_wr), .test_addr(test_addr), .test_din(test_din),
        .test_start(test_start), .fail_high(fail_high), .fail_low(fail_low),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_refresh(mem_refresh),
        .mem_addr(mem_addr), .mem_din(mem_din), .mem_wmask(mem_wmask),
        .mem_dout(mem_dout), .mem_data_ready(mem_data_ready), .mem_busy(mem_busy)
    );

    mem_selftest #(.ADDR_WIDTH(ADDR_WIDTH), .TEST_WORDS(TEST_WORDS)) u_selftest (
        .clk(clk), .resetn(resetn), .test_start(test_start),
        .mem_dout(mem_dout), .mem_data_ready(mem_data_ready), .mem_busy(mem_busy),
        .test_rd(test_rd), .test_wr(test_wr), .test_addr(test_addr), .test_din(test_din),
        .test_running(test_running), .fail_high(test_fail_high), .fail_low(test_fail_low)
    );

    word_store #(
        .ADDR_WIDTH(ADDR_WIDTH), .INIT_CYCLES(INIT_CYCLES),
        .ACCESS_CYCLES(ACCESS_CYCLES), .REFRESH_CYCLES(REFRESH_CYCLES)
    ) u_store (
        .clk(clk), .resetn(resetn),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_refresh(mem_refresh),
        .mem_addr(mem_addr), .mem_din(mem_din), .mem_wmask(mem_wmask),
        .mem_dout(mem_dout), .mem_data_ready(mem_data_ready), .mem_busy(mem_busy)
    );

endmodule

//--- hdl/mem_bridge.sv
// console byte strobes to store words, init/test sequencing and command mux
`timescale 1ns/1ns

module mem_bridge #(
    parameter int ADDR_WIDTH = 22    // console byte address width
) (
    input  logic                           clk,
    input  logic                           resetn,
    // console side
    input  logic                           read_a,
    input  logic                           read_b,
    input  logic                           write,
    input  logic                           refresh,
    input  logic [ADDR_WIDTH-1:0]          addr,            // byte address
    input  mem_pkg::byte_t                 din,
    output mem_pkg::byte_t                 dout_a,
    output mem_pkg::byte_t                 dout_b,
    output logic                           busy,
    output logic [19:0]                    total_written,
    // self-test side
    input  logic                           test_running,
    input  logic                           fail_high_in,
    input  logic                           fail_low_in,
    input  logic                           test_rd,
    input  logic                           test_wr,
    input  logic [ADDR_WIDTH-2:0]          test_addr,
    input  mem_pkg::word_t                 test_din,
    output logic                           test_start,
    output logic                           fail_high,
    output logic                           fail_low,
    // store side
    output logic                           mem_rd,
    output logic                           mem_wr,
    output logic                           mem_refresh,
    output logic [ADDR_WIDTH-2:0]          mem_addr,        // word address
    output mem_pkg::word_t                 mem_din,
    output logic [mem_pkg::WORD_BYTES-1:0] mem_wmask,
    input  mem_pkg::word_t                 mem_dout,
    input  logic                           mem_data_ready,
    input  logic                           mem_busy
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        INIT,      // store counting down
        TEST,      // self-test in progress or failed
        NORMAL     // serving console strobes
    } state_t;

    state_t                state;
    logic                  req_rd;        // own command pulses one cycle after accept
    logic                  req_wr;
    logic                  req_refresh;
    logic [ADDR_WIDTH-2:0] req_addr;
    word_t                 req_din;
    logic [WORD_BYTES-1:0] req_wmask;
    logic                  r_read_a;      // which ports wait for data
    logic                  r_read_b;
    logic                  r_lane;        // 1 selects high lane
    logic                  store_seen;    // store went busy on our command
    logic                  any_read;
    logic                  accept;
    byte_t                 lane_byte;

    assign any_read  = read_a | read_b;
    assign accept    = (state == NORMAL) & ~busy & (any_read | write | refresh);
    assign lane_byte = r_lane ? mem_dout[15:8] : mem_dout[7:0];

    // self-test owns the store while running and always writes both lanes
    assign mem_rd      = test_running ? test_rd   : req_rd;
    assign mem_wr      = test_running ? test_wr   : req_wr;
    assign mem_refresh = test_running ? 1'b0      : req_refresh;
    assign mem_addr    = test_running ? test_addr : req_addr;
    assign mem_din     = test_running ? test_din  : req_din;
    assign mem_wmask   = test_running ? '1        : req_wmask;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state         <= INIT;
            busy          <= 1'b1;
            test_start    <= 1'b0;
            req_rd        <= 1'b0;
            req_wr        <= 1'b0;
            req_refresh   <= 1'b0;
            r_read_a      <= 1'b0;
            r_read_b      <= 1'b0;
            store_seen    <= 1'b0;
            total_written <= '0;
            fail_high     <= 1'b0;
            fail_low      <= 1'b0;
        end else begin
            test_start  <= 1'b0;
            req_rd      <= 1'b0;
            req_wr      <= 1'b0;
            req_refresh <= 1'b0;
            fail_high   <= fail_high_in;   // console copies of the flags
            fail_low    <= fail_low_in;
            case (state)
                INIT: if (!mem_busy) begin
                    test_start <= 1'b1;     // init done so kick off the self-test
                    state      <= TEST;
                end
                TEST: begin
                    // test_start guards the cycle before test_running rises
                    if (!test_start && !test_running && !fail_high_in && !fail_low_in) begin
                        state <= NORMAL;
                        busy  <= 1'b0;
                    end
                end
                NORMAL: if (accept) begin
                    busy        <= 1'b1;
                    req_rd      <= any_read;                       // read has priority
                    req_wr      <= write & ~any_read;
                    req_refresh <= refresh & ~any_read & ~write;
                    r_read_a    <= read_a;
                    r_read_b    <= read_b;
                    store_seen  <= 1'b0;
                    if (write && !any_read)
                        total_written <= total_written + 1'b1;
                end else if (busy) begin
                    if (mem_busy) store_seen <= 1'b1;
                    if ((r_read_a || r_read_b) && mem_data_ready) begin
                        busy     <= 1'b0;   // data latched on this edge by the block below
                        r_read_a <= 1'b0;
                        r_read_b <= 1'b0;
                    end else if (!r_read_a && !r_read_b && store_seen && !mem_busy) begin
                        busy <= 1'b0;       // write or refresh done
                    end
                end
                default: state <= INIT;
            endcase
        end
    end

    // request payload and read latches
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= addr[ADDR_WIDTH-1:1];
            req_din   <= {din, din};           // same byte on both lanes
            req_wmask <= {addr[0], ~addr[0]};  // mask picks the lane
            r_lane    <= addr[0];
        end
        if (r_read_a && mem_data_ready) dout_a <= lane_byte;
        if (r_read_b && mem_data_ready) dout_b <= lane_byte;
    end

endmodule

//--- hdl/mem_selftest.sv
// write then read-back pattern test engine with per-lane sticky fail flags
`timescale 1ns/1ns

module mem_selftest #(
    parameter int ADDR_WIDTH = 22,    // byte address width
    parameter int TEST_WORDS = 16     // words covered by the test
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  test_start,      // one-cycle start pulse
    input  mem_pkg::word_t        mem_dout,
    input  logic                  mem_data_ready,
    input  logic                  mem_busy,
    output logic                  test_rd,         // read command pulse
    output logic                  test_wr,         // write command pulse
    output logic [ADDR_WIDTH-2:0] test_addr,       // word address
    output mem_pkg::word_t        test_din,
    output logic                  test_running,
    output logic                  fail_high,       // high lane mismatch seen
    output logic                  fail_low         // low lane mismatch seen
);
    import mem_pkg::*;

    localparam int AW = ADDR_WIDTH - 1;    // word address width

    typedef enum logic [2:0] {
        IDLE,        // waiting for start
        WR_ISSUE,    // wait for store idle before the write
        WR_WAIT,     // wait for store to pick up the write
        RD_ISSUE,    // wait for store idle before the read
        RD_WAIT      // wait for the read data
    } state_t;

    state_t        state;
    logic [AW-1:0] idx;          // current word index for both passes
    word_t         exp_word;     // pattern for the current index
    logic          last_word;

    assign exp_word  = test_pattern(32'(idx));
    assign last_word = (idx == AW'(TEST_WORDS - 1));
    assign test_addr = idx;
    assign test_din  = exp_word;  // only looked at on write pass

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= IDLE;
            idx          <= '0;
            test_rd      <= 1'b0;
            test_wr      <= 1'b0;
            test_running <= 1'b0;
            fail_high    <= 1'b0;
            fail_low     <= 1'b0;
        end else begin
            test_rd <= 1'b0;   // commands are single pulses
            test_wr <= 1'b0;
            case (state)
                IDLE: if (test_start) begin
                    idx          <= '0;
                    test_running <= 1'b1;
                    fail_high    <= 1'b0;   // flags cleared for a fresh run
                    fail_low     <= 1'b0;
                    state        <= WR_ISSUE;
                end
                WR_ISSUE: if (!mem_busy) begin
                    test_wr <= 1'b1;        // lands one cycle after idle seen
                    state   <= WR_WAIT;
                end
                WR_WAIT: if (mem_busy) begin
                    // store has latched address and data
                    if (last_word) begin
                        idx   <= '0;
                        state <= RD_ISSUE;  // switch to read-back pass
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= WR_ISSUE;
                    end
                end
                RD_ISSUE: if (!mem_busy) begin
                    test_rd <= 1'b1;
                    state   <= RD_WAIT;
                end
                RD_WAIT: if (mem_data_ready) begin
                    if (mem_dout[15:8] != exp_word[15:8]) fail_high <= 1'b1;   // sticky
                    if (mem_dout[7:0] != exp_word[7:0])   fail_low  <= 1'b1;
                    if (last_word) begin
                        test_running <= 1'b0;   // flags are final from here
                        state        <= IDLE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= RD_ISSUE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- hdl/word_store.sv
// 16-bit word memory with lane write mask, init countdown and fixed-latency access
`timescale 1ns/1ns

module word_store #(
    parameter int ADDR_WIDTH     = 22,     // byte address width of the console side
    parameter int INIT_CYCLES    = 200,    // power-up countdown length
    parameter int ACCESS_CYCLES  = 3,      // read / write occupancy
    parameter int REFRESH_CYCLES = 6       // refresh occupancy
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              mem_rd,          // read command pulse
    input  logic                              mem_wr,          // write command pulse
    input  logic                              mem_refresh,     // refresh command pulse
    input  logic [ADDR_WIDTH-2:0]             mem_addr,        // word address
    input  mem_pkg::word_t                    mem_din,
    input  logic [mem_pkg::WORD_BYTES-1:0]    mem_wmask,       // per-lane write enable
    output mem_pkg::word_t                    mem_dout,
    output logic                              mem_data_ready,  // pulse in last read cycle
    output logic                              mem_busy
);
    import mem_pkg::*;

    localparam int DEPTH = 2 ** (ADDR_WIDTH - 1);
    // wide enough for the longest of the three occupancies
    localparam int CNT_W = $clog2(INIT_CYCLES + ACCESS_CYCLES + REFRESH_CYCLES + 1);

    word_t            mem [DEPTH];   // the word array itself
    logic [CNT_W-1:0] cnt;           // cycles left in current occupancy minus one
    logic             rd_pend;       // current occupancy belongs to a read
    logic             accept;        // command taken this cycle

    assign accept = ~mem_busy & (mem_rd | mem_wr | mem_refresh);

    // data ready sits on the final busy cycle of a read
    assign mem_data_ready = mem_busy & rd_pend & (cnt == '0);

    // occupancy counter shared by init, access and refresh
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt      <= CNT_W'(INIT_CYCLES - 1);   // init countdown starts here
            mem_busy <= 1'b1;
            rd_pend  <= 1'b0;
        end else if (mem_busy) begin
            if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else begin
                mem_busy <= 1'b0;                  // occupancy over
                rd_pend  <= 1'b0;
            end
        end else if (mem_rd || mem_wr) begin
            cnt      <= CNT_W'(ACCESS_CYCLES - 1);
            mem_busy <= 1'b1;                      // busy from the next cycle on
            rd_pend  <= mem_rd;                    // read wins over write
        end else if (mem_refresh) begin
            cnt      <= CNT_W'(REFRESH_CYCLES - 1);
            mem_busy <= 1'b1;
            rd_pend  <= 1'b0;
        end
    end

    // array access with the read word taken at accept and held until the next read
    always_ff @(posedge clk) begin
        if (accept && mem_rd) begin
            mem_dout <= mem[mem_addr];
        end else if (accept && mem_wr) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                if (mem_wmask[i])
                    mem[mem_addr][BYTE_BITS*i +: BYTE_BITS] <= mem_din[BYTE_BITS*i +: BYTE_BITS];
            end
        end
        // refresh leaves the array untouched
    end

endmodule

//--- hdl/mem_pkg.sv
// word and byte types, lane sizes and self-test pattern function for the memory subsystem
package mem_pkg;

    localparam int BYTE_BITS  = 8;                      // console data width
    localparam int WORD_BYTES = 2;                      // byte lanes per store word
    localparam int WORD_BITS  = WORD_BYTES * BYTE_BITS; // store word width

    // one console data byte
    typedef logic [BYTE_BITS-1:0] byte_t;

    // one store word with the high lane in bits 15..8 and the low lane in bits 7..0
    typedef logic [WORD_BITS-1:0] word_t;

    // self-test word for a given word index
    // high lane is the index xor 5a and low lane is the inverted index
    // so the two lanes never carry the same byte
    function automatic word_t test_pattern(input logic [31:0] index);
        byte_t idx_byte;
        byte_t high_lane;
        byte_t low_lane;
        idx_byte  = index[BYTE_BITS-1:0];   // only the low byte matters
        high_lane = idx_byte ^ 8'h5A;
        low_lane  = ~idx_byte;
        return {high_lane, low_lane};
    endfunction

endpackage
